// ==== design/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

  // Datapath widths
  localparam int data_w       = 64;
  localparam int reg_w        = 5;
  localparam int history_bits = 8;

  // Multiplier geometry: four 16-bit slices of the multiplier
  localparam int slice_w     = 16;
  localparam int mult_stages = 4;

  // ALU function select
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,
    alu_bis    = 5'h04,
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_cmpult = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmpule = 5'h0d,
    alu_cmplt  = 5'h0e,
    alu_cmple  = 5'h0f
  } alu_func_t;

  // Branch outcome reported on writeback
  typedef enum logic [1:0] {
    br_none      = 2'b00,
    br_taken     = 2'b01,
    br_not_taken = 2'b10,
    br_halt      = 2'b11
  } br_result_t;

  // Primary opcode, IR[31:26]; unnamed codes are legal too
  typedef enum logic [5:0] {
    intop_grp = 6'h10,
    mul_grp   = 6'h13,
    jsr_grp   = 6'h1a,
    br_inst   = 6'h30,
    bsr_inst  = 6'h34
  } opcode_t;

  localparam logic [31:0] halt_instruction = 32'h0000_0555;

endpackage

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire logic [ex_pkg::data_w-1:0] opa,
  input  wire logic [ex_pkg::data_w-1:0] opb,
  input  wire ex_pkg::alu_func_t         func,
  output logic      [ex_pkg::data_w-1:0] result
);

  import ex_pkg::*;

  // Value driven for an unassigned function code
  localparam logic [data_w-1:0] poison = 64'hdead_beef_baad_beef;

  logic [5:0] shamt;
  logic       ult;
  logic       eq;
  logic       slt;

  assign shamt = opb[5:0];
  assign ult   = opa < opb;
  assign eq    = opa == opb;

  // Signed less-than from the sign bits
  // same sign: unsigned compare holds, else opa is smaller if negative
  assign slt = (opa[data_w-1] == opb[data_w-1]) ? ult : opa[data_w-1];

  always_comb begin
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = $unsigned($signed(opa) >>> shamt);
      alu_cmpult: result = {{(data_w-1){1'b0}}, ult};
      alu_cmpeq:  result = {{(data_w-1){1'b0}}, eq};
      alu_cmpule: result = {{(data_w-1){1'b0}}, ult | eq};
      alu_cmplt:  result = {{(data_w-1){1'b0}}, slt};
      alu_cmple:  result = {{(data_w-1){1'b0}}, slt | eq};
      default:    result = poison;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/brcond.sv ====
`timescale 1ns/1ps
`default_nettype none

module brcond (
  input  wire logic [ex_pkg::data_w-1:0] opa,
  input  wire logic [2:0]                func,
  output logic                           cond
);

  import ex_pkg::*;

  logic is_zero;
  logic is_neg;
  logic raw;

  assign is_zero = opa == '0;
  assign is_neg  = opa[data_w-1];

  always_comb begin
    case (func[1:0])
      2'b00:   raw = ~opa[0];
      2'b01:   raw = is_zero;
      2'b10:   raw = is_neg;
      default: raw = is_neg | is_zero;
    endcase
  end

  // Bit 2 selects the inverted sense (bne, bge, bgt, blbs)
  assign cond = raw ^ func[2];

endmodule

`default_nettype wire

// ==== design/mult_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_stage (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire logic                      start,
  input  wire logic                      stall,
  input  wire logic [ex_pkg::data_w-1:0] npc_in,
  input  wire logic [ex_pkg::reg_w-1:0]  dest_in,
  input  wire logic [ex_pkg::data_w-1:0] product_in,
  input  wire logic [ex_pkg::data_w-1:0] mplier_in,
  input  wire logic [ex_pkg::data_w-1:0] mcand_in,
  output logic      [ex_pkg::data_w-1:0] npc_out,
  output logic      [ex_pkg::reg_w-1:0]  dest_out,
  output logic      [ex_pkg::data_w-1:0] product_out,
  output logic      [ex_pkg::data_w-1:0] mplier_out,
  output logic      [ex_pkg::data_w-1:0] mcand_out,
  output logic                           done
);

  import ex_pkg::*;

  logic [data_w-1:0] prod_in_reg;
  logic [data_w-1:0] partial_prod_reg;
  logic [data_w-1:0] partial_product;

  // Low slice of the multiplier against the full multiplicand
  assign partial_product = {{(data_w-slice_w){1'b0}}, mplier_in[slice_w-1:0]} * mcand_in;

  assign product_out = prod_in_reg + partial_prod_reg;

  always_ff @(posedge clock) begin
    if (!stall) begin
      prod_in_reg      <= product_in;
      partial_prod_reg <= partial_product;
      mplier_out       <= mplier_in >> slice_w;
      mcand_out        <= mcand_in << slice_w;
      npc_out          <= npc_in;
      dest_out         <= dest_in;
    end
  end

  // Valid bit marches with the data and freezes under stall
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (!stall) begin
      done <= start;
    end
  end

  a_done_known: assert property (
    @(posedge clock) disable iff (reset) !$isunknown(done)
  ) else $error("mult_stage done went unknown");

endmodule

`default_nettype wire

// ==== design/mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire logic                      valid_in,
  input  wire logic                      stall,
  input  wire logic [ex_pkg::data_w-1:0] mplier,
  input  wire logic [ex_pkg::data_w-1:0] mcand,
  input  wire logic [ex_pkg::data_w-1:0] npc_in,
  input  wire logic [ex_pkg::reg_w-1:0]  dest_in,
  output logic      [ex_pkg::data_w-1:0] product,
  output logic      [ex_pkg::data_w-1:0] npc_out,
  output logic      [ex_pkg::reg_w-1:0]  dest_out,
  output logic                           valid_out
);

  import ex_pkg::*;

  // Index i is the input of stage i, index mult_stages the final output
  logic [data_w-1:0] product_chain [0:mult_stages];
  logic [data_w-1:0] mplier_chain  [0:mult_stages];
  logic [data_w-1:0] mcand_chain   [0:mult_stages];
  logic [data_w-1:0] npc_chain     [0:mult_stages];
  logic [reg_w-1:0]  dest_chain    [0:mult_stages];
  logic [mult_stages:0] done_chain;

  // First stage starts from a zero partial sum
  assign product_chain[0] = '0;
  assign mplier_chain[0]  = mplier;
  assign mcand_chain[0]   = mcand;
  assign npc_chain[0]     = npc_in;
  assign dest_chain[0]    = dest_in;
  assign done_chain[0]    = valid_in;

  for (genvar i = 0; i < mult_stages; i++) begin : g_stage
    mult_stage u_stage (
      .clock       (clock),
      .reset       (reset),
      .start       (done_chain[i]),
      .stall       (stall),
      .npc_in      (npc_chain[i]),
      .dest_in     (dest_chain[i]),
      .product_in  (product_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .npc_out     (npc_chain[i+1]),
      .dest_out    (dest_chain[i+1]),
      .product_out (product_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1]),
      .done        (done_chain[i+1])
    );
  end

  // Low 64 bits of the full product
  assign product   = product_chain[mult_stages];
  assign npc_out   = npc_chain[mult_stages];
  assign dest_out  = dest_chain[mult_stages];
  assign valid_out = done_chain[mult_stages];

endmodule

`default_nettype wire

// ==== design/ex_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_arbiter (
  input  wire logic [31:0]                     ir,
  input  wire logic                            alu_valid,
  input  wire logic [ex_pkg::data_w-1:0]       alu_result,
  input  wire logic [ex_pkg::data_w-1:0]       alu_npc,
  input  wire logic [ex_pkg::reg_w-1:0]        alu_dest,
  input  wire logic                            br_valid,
  input  wire logic                            br_taken,
  input  wire logic                            br_mispredict,
  input  wire logic [ex_pkg::history_bits-1:0] pht_idx,
  input  wire logic                            mult_valid,
  input  wire logic [ex_pkg::data_w-1:0]       mult_result,
  input  wire logic [ex_pkg::data_w-1:0]       mult_npc,
  input  wire logic [ex_pkg::reg_w-1:0]        mult_dest,
  input  wire logic                            mem_valid,
  input  wire logic [ex_pkg::reg_w-1:0]        mem_tag,
  input  wire logic [ex_pkg::data_w-1:0]       mem_value,
  output logic                                 stall_alu,
  output logic                                 stall_mult,
  output logic                                 wb_valid,
  output logic      [ex_pkg::data_w-1:0]       wb_npc,
  output logic      [ex_pkg::reg_w-1:0]        wb_dest,
  output logic      [ex_pkg::data_w-1:0]       wb_result,
  output logic      [ex_pkg::data_w-1:0]       wb_cpc,
  output logic                                 wb_mispredict,
  output ex_pkg::br_result_t                   wb_br_result,
  output logic      [ex_pkg::history_bits-1:0] wb_pht_idx
);

  import ex_pkg::*;

  opcode_t opcode;
  logic    writes_link;

  assign opcode      = opcode_t'(ir[31:26]);
  assign writes_link = (opcode == jsr_grp) || (opcode == bsr_inst);

  assign wb_pht_idx = pht_idx;

  // Fixed priority: memory, then multiplier, then ALU/branch
  always_comb begin
    stall_mult    = 1'b0;
    stall_alu     = 1'b0;
    wb_mispredict = 1'b0;
    wb_br_result  = br_none;
    if (mem_valid) begin
      // A finished product waits in its stage
      stall_mult = mult_valid;
      stall_alu  = 1'b1;
      wb_valid   = 1'b1;
      wb_npc     = mult_npc;
      wb_dest    = mem_tag;
      wb_result  = mem_value;
      wb_cpc     = mem_value;
    end else if (mult_valid) begin
      stall_alu = 1'b1;
      wb_valid  = 1'b1;
      wb_npc    = mult_npc;
      wb_dest   = mult_dest;
      wb_result = mult_result;
      wb_cpc    = mult_result;
    end else begin
      wb_npc  = alu_npc;
      wb_dest = alu_dest;
      wb_cpc  = alu_result;
      if (br_valid) begin
        wb_valid      = 1'b1;
        wb_mispredict = br_mispredict;
        // The port br_taken hides the enum value of the same name
        wb_br_result  = br_taken ? ex_pkg::br_taken : br_not_taken;
        // Subroutine calls write the return address
        wb_result     = writes_link ? alu_npc : alu_result;
      end else begin
        wb_valid     = alu_valid;
        wb_br_result = (ir == halt_instruction) ? br_halt : br_none;
        wb_result    = alu_result;
      end
    end
  end

  always_comb begin
    a_stall_mult_mem: assert (!stall_mult || mem_valid)
      else $error("stall_mult raised without a memory return");
  end

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire logic                            clock,
  input  wire logic                            reset,
  // ALU issue
  input  wire logic                            alu_valid,
  input  wire ex_pkg::alu_func_t               alu_func,
  input  wire logic [ex_pkg::data_w-1:0]       opa,
  input  wire logic [ex_pkg::data_w-1:0]       opb,
  input  wire logic [ex_pkg::data_w-1:0]       npc,
  input  wire logic [ex_pkg::reg_w-1:0]        dest_reg,
  input  wire logic [31:0]                     ir,
  // Branch qualifiers of the ALU issue
  input  wire logic                            br_valid,
  input  wire logic [2:0]                      br_func,
  input  wire logic                            br_pred_taken,
  input  wire logic [ex_pkg::history_bits-1:0] pht_idx,
  // Multiply issue
  input  wire logic                            mult_valid,
  input  wire logic [ex_pkg::data_w-1:0]       mplier,
  input  wire logic [ex_pkg::data_w-1:0]       mcand,
  input  wire logic [ex_pkg::data_w-1:0]       mult_npc,
  input  wire logic [ex_pkg::reg_w-1:0]        mult_dest,
  // Memory return
  input  wire logic                            mem_valid,
  input  wire logic [ex_pkg::reg_w-1:0]        mem_tag,
  input  wire logic [ex_pkg::data_w-1:0]       mem_value,
  // Writeback bus
  output logic                                 wb_valid,
  output logic      [ex_pkg::data_w-1:0]       wb_npc,
  output logic      [ex_pkg::reg_w-1:0]        wb_dest,
  output logic      [ex_pkg::data_w-1:0]       wb_result,
  output logic      [ex_pkg::data_w-1:0]       wb_cpc,
  output logic                                 wb_mispredict,
  output ex_pkg::br_result_t                   wb_br_result,
  output logic      [ex_pkg::history_bits-1:0] wb_pht_idx,
  output logic                                 stall_alu,
  output logic                                 stall_mult
);

  import ex_pkg::*;

  logic [data_w-1:0] alu_result;
  logic              br_taken;
  logic              br_mispredict;
  logic [data_w-1:0] prod;
  logic [data_w-1:0] prod_npc;
  logic [reg_w-1:0]  prod_dest;
  logic              prod_valid;

  alu u_alu (
    .opa    (opa),
    .opb    (opb),
    .func   (alu_func),
    .result (alu_result)
  );

  // Condition is tested on opa, the ALU computes the target
  brcond u_brcond (
    .opa  (opa),
    .func (br_func),
    .cond (br_taken)
  );

  assign br_mispredict = br_taken != br_pred_taken;

  mult u_mult (
    .clock     (clock),
    .reset     (reset),
    .valid_in  (mult_valid),
    .stall     (stall_mult),
    .mplier    (mplier),
    .mcand     (mcand),
    .npc_in    (mult_npc),
    .dest_in   (mult_dest),
    .product   (prod),
    .npc_out   (prod_npc),
    .dest_out  (prod_dest),
    .valid_out (prod_valid)
  );

  ex_arbiter u_arbiter (
    .ir            (ir),
    .alu_valid     (alu_valid),
    .alu_result    (alu_result),
    .alu_npc       (npc),
    .alu_dest      (dest_reg),
    .br_valid      (br_valid),
    .br_taken      (br_taken),
    .br_mispredict (br_mispredict),
    .pht_idx       (pht_idx),
    .mult_valid    (prod_valid),
    .mult_result   (prod),
    .mult_npc      (prod_npc),
    .mult_dest     (prod_dest),
    .mem_valid     (mem_valid),
    .mem_tag       (mem_tag),
    .mem_value     (mem_value),
    .stall_alu     (stall_alu),
    .stall_mult    (stall_mult),
    .wb_valid      (wb_valid),
    .wb_npc        (wb_npc),
    .wb_dest       (wb_dest),
    .wb_result     (wb_result),
    .wb_cpc        (wb_cpc),
    .wb_mispredict (wb_mispredict),
    .wb_br_result  (wb_br_result),
    .wb_pht_idx    (wb_pht_idx)
  );

  // Branch flag only qualifies an ALU issue
  a_br_with_alu: assert property (
    @(posedge clock) disable iff (reset) br_valid |-> alu_valid
  ) else $error("br_valid without alu_valid");

  // A product held by stall_mult stays on the multiplier output
  a_prod_held: assert property (
    @(posedge clock) disable iff (reset) stall_mult |=> prod_valid && $stable(prod)
  ) else $error("product changed under stall_mult");

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  // 40 ns period
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Reset held over the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

  import ex_pkg::*;

  localparam int wait_limit = 5 * mult_stages;

  logic              clock;
  logic              reset;
  logic              alu_valid;
  alu_func_t         alu_func;
  logic [63:0]       opa;
  logic [63:0]       opb;
  logic [63:0]       npc;
  logic [4:0]        dest_reg;
  logic [31:0]       ir;
  logic              br_valid;
  logic [2:0]        br_func;
  logic              br_pred_taken;
  logic [7:0]        pht_idx;
  logic              mult_valid;
  logic [63:0]       mplier;
  logic [63:0]       mcand;
  logic [63:0]       mult_npc;
  logic [4:0]        mult_dest;
  logic              mem_valid;
  logic [4:0]        mem_tag;
  logic [63:0]       mem_value;
  logic              wb_valid;
  logic [63:0]       wb_npc;
  logic [4:0]        wb_dest;
  logic [63:0]       wb_result;
  logic [63:0]       wb_cpc;
  logic              wb_mispredict;
  br_result_t        wb_br_result;
  logic [7:0]        wb_pht_idx;
  logic              stall_alu;
  logic              stall_mult;

  integer seed;
  int     check_count;
  int     error_count;
  logic   timed_out;

  tb_clock clock_gen (
    .clock (clock),
    .reset (reset)
  );

  ex_stage uut (
    .clock (clock), .reset (reset),
    .alu_valid (alu_valid), .alu_func (alu_func), .opa (opa), .opb (opb),
    .npc (npc), .dest_reg (dest_reg), .ir (ir),
    .br_valid (br_valid), .br_func (br_func), .br_pred_taken (br_pred_taken),
    .pht_idx (pht_idx),
    .mult_valid (mult_valid), .mplier (mplier), .mcand (mcand),
    .mult_npc (mult_npc), .mult_dest (mult_dest),
    .mem_valid (mem_valid), .mem_tag (mem_tag), .mem_value (mem_value),
    .wb_valid (wb_valid), .wb_npc (wb_npc), .wb_dest (wb_dest),
    .wb_result (wb_result), .wb_cpc (wb_cpc), .wb_mispredict (wb_mispredict),
    .wb_br_result (wb_br_result), .wb_pht_idx (wb_pht_idx),
    .stall_alu (stall_alu), .stall_mult (stall_mult)
  );

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Reference ALU, straight from the instruction definitions
  function automatic logic [63:0] alu_model(input alu_func_t f, input logic [63:0] a,
                                            input logic [63:0] b);
    logic [63:0] r;
    case (f)
      alu_addq:   r = a + b;
      alu_subq:   r = a - b;
      alu_and:    r = a & b;
      alu_bic:    r = a & ~b;
      alu_bis:    r = a | b;
      alu_ornot:  r = a | ~b;
      alu_xor:    r = a ^ b;
      alu_eqv:    r = ~(a ^ b);
      alu_srl:    r = a >> b[5:0];
      alu_sll:    r = a << b[5:0];
      alu_sra:    r = 64'($signed(a) >>> b[5:0]);
      alu_cmpult: r = (a < b) ? 64'd1 : 64'd0;
      alu_cmpeq:  r = (a == b) ? 64'd1 : 64'd0;
      alu_cmpule: r = (a <= b) ? 64'd1 : 64'd0;
      alu_cmplt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_cmple:  r = ($signed(a) <= $signed(b)) ? 64'd1 : 64'd0;
      default:    r = 'x;
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("%s: %0d checks, %0d errors", name, check_count - chk0, error_count - err0);
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (reset && cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (reset) begin
      $display("Reset never released within %0d cycles", wait_limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_reset_state();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    check_value("wb_valid", 64'(wb_valid), 64'd0);
    check_value("stall_alu", 64'(stall_alu), 64'd0);
    check_value("stall_mult", 64'(stall_mult), 64'd0);
    report_test("reset_state", chk0, err0);
  endtask

  task automatic test_alu_ops();
    logic [63:0] edge_vals [3];
    logic [63:0] a;
    logic [63:0] b;
    logic        v;
    alu_func_t   f;
    int          n;
    int          chk0;
    int          err0;
    chk0 = check_count;
    err0 = error_count;
    edge_vals[0] = 64'd0;
    edge_vals[1] = '1;
    edge_vals[2] = 64'h8000_0000_0000_0000;
    n = 0;
    for (int fi = 0; fi < 16; fi++) begin
      f = alu_func_t'(fi[4:0]);
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          a = (i < 3) ? edge_vals[i] : random_word();
          b = (j < 3) ? edge_vals[j] : random_word();
          v = (n % 3) != 0;
          @(posedge clock);
          alu_valid <= v;
          alu_func  <= f;
          opa       <= a;
          opb       <= b;
          @(negedge clock);
          check_value("wb_result", wb_result, alu_model(f, a, b));
          check_value("wb_valid", 64'(wb_valid), 64'(v));
          n++;
        end
      end
    end
    report_test("alu_ops", chk0, err0);
  endtask

  task automatic test_branches();
    logic [5:0]  ops [3];
    logic [63:0] sign;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] np;
    logic [63:0] r;
    logic [2:0]  bf;
    logic        want;
    logic        pred;
    logic        taken;
    logic [7:0]  idx;
    logic [4:0]  dst;
    logic [31:0] ir_v;
    int          chk0;
    int          err0;
    chk0 = check_count;
    err0 = error_count;
    ops[0] = jsr_grp;
    ops[1] = bsr_inst;
    ops[2] = br_inst;
    sign = 64'h8000_0000_0000_0000;
    for (int fi = 0; fi < 8; fi++) begin
      for (int w = 0; w < 2; w++) begin
        for (int p = 0; p < 2; p++) begin
          for (int o = 0; o < 3; o++) begin
            bf   = fi[2:0];
            want = w[0];
            pred = p[0];
            a    = random_word();
            // Shape opa so the raw condition is true or false
            case (bf[1:0])
              2'b00:   a = want ? {a[63:1], 1'b0} : {a[63:1], 1'b1};
              2'b01:   a = want ? 64'd0 : (a | 64'd1);
              2'b10:   a = want ? (a | sign) : (a & ~sign);
              default: a = want ? ((p == 0) ? 64'd0 : (a | sign)) : ((a & ~sign) | 64'd1);
            endcase
            taken = want ^ bf[2];
            b     = random_word();
            np    = random_word();
            r     = random_word();
            idx   = r[7:0];
            dst   = r[12:8];
            ir_v  = {ops[o], r[45:20]};
            @(posedge clock);
            alu_valid     <= 1'b1;
            alu_func      <= alu_addq;
            opa           <= a;
            opb           <= b;
            npc           <= np;
            dest_reg      <= dst;
            ir            <= ir_v;
            br_valid      <= 1'b1;
            br_func       <= bf;
            br_pred_taken <= pred;
            pht_idx       <= idx;
            @(negedge clock);
            check_value("wb_valid", 64'(wb_valid), 64'd1);
            check_value("wb_br_result", 64'(wb_br_result),
                        taken ? 64'(br_taken) : 64'(br_not_taken));
            check_value("wb_mispredict", 64'(wb_mispredict), 64'(taken != pred));
            check_value("wb_cpc", wb_cpc, a + b);
            check_value("wb_result", wb_result, (o < 2) ? np : a + b);
            check_value("wb_npc", wb_npc, np);
            check_value("wb_dest", 64'(wb_dest), 64'(dst));
            check_value("wb_pht_idx", 64'(wb_pht_idx), 64'(idx));
          end
        end
      end
    end
    @(posedge clock);
    br_valid <= 1'b0;
    ir       <= 32'd0;
    report_test("branches", chk0, err0);
  endtask

  task automatic test_halt();
    logic [31:0] ir_v;
    logic        is_halt;
    int          chk0;
    int          err0;
    chk0 = check_count;
    err0 = error_count;
    for (int k = 0; k < 10; k++) begin
      // Even steps use the exact halt word, odd steps flip one bit
      ir_v    = (k % 2 == 0) ? halt_instruction : halt_instruction ^ (32'd1 << (k * 3));
      is_halt = (k % 2 == 0);
      @(posedge clock);
      alu_valid <= 1'b1;
      br_valid  <= 1'b0;
      ir        <= ir_v;
      @(negedge clock);
      check_value("wb_br_result", 64'(wb_br_result),
                  is_halt ? 64'(br_halt) : 64'(br_none));
      check_value("wb_valid", 64'(wb_valid), 64'd1);
    end
    @(posedge clock);
    ir <= 32'd0;
    report_test("halt", chk0, err0);
  endtask

  // Scoreboard for the multiplier; entries count unstalled edges left
  task automatic run_mult_sequence(input string name, input int n, input int mem_start,
                                   input int mem_len);
    logic [63:0] a_list [8];
    logic [63:0] b_list [8];
    logic [63:0] npc_list [8];
    logic [4:0]  dest_list [8];
    logic [63:0] q_prod [$];
    logic [63:0] q_npc [$];
    logic [4:0]  q_dest [$];
    int          q_left [$];
    logic [63:0] r;
    logic [63:0] m_value;
    logic [4:0]  m_tag;
    logic        held;
    logic        in_mem;
    logic        front_ready;
    int          issued;
    int          seen;
    int          cycle;
    int          chk0;
    int          err0;
    chk0 = check_count;
    err0 = error_count;
    for (int i = 0; i < n; i++) begin
      a_list[i]    = random_word();
      b_list[i]    = random_word();
      npc_list[i]  = random_word();
      r            = random_word();
      dest_list[i] = r[4:0];
    end
    m_value = random_word();
    r       = random_word();
    m_tag   = r[4:0];
    held    = 1'b0;
    issued  = 0;
    seen    = 0;
    cycle   = 0;
    while ((issued < n || q_prod.size() > 0) && !timed_out) begin
      @(posedge clock);
      if (!held) begin
        if (q_left.size() > 0 && q_left[0] == 0) begin
          q_prod.delete(0);
          q_npc.delete(0);
          q_dest.delete(0);
          q_left.delete(0);
        end
        foreach (q_left[k]) q_left[k] = q_left[k] - 1;
        // The pair presented in the cycle just ended is taken
        if (mult_valid) begin
          q_prod.push_back(a_list[issued] * b_list[issued]);
          q_npc.push_back(npc_list[issued]);
          q_dest.push_back(dest_list[issued]);
          q_left.push_back(mult_stages - 1);
          issued++;
        end
      end
      in_mem = cycle >= mem_start && cycle < mem_start + mem_len;
      alu_valid  <= 1'b0;
      br_valid   <= 1'b0;
      mult_valid <= issued < n;
      if (issued < n) begin
        mplier    <= a_list[issued];
        mcand     <= b_list[issued];
        mult_npc  <= npc_list[issued];
        mult_dest <= dest_list[issued];
      end
      mem_valid <= in_mem;
      mem_tag   <= m_tag;
      mem_value <= m_value;
      @(negedge clock);
      front_ready = q_left.size() > 0 && q_left[0] == 0;
      if (in_mem) begin
        check_value("wb_valid", 64'(wb_valid), 64'd1);
        check_value("wb_result", wb_result, m_value);
        check_value("wb_dest", 64'(wb_dest), 64'(m_tag));
        check_value("stall_alu", 64'(stall_alu), 64'd1);
      end else if (front_ready) begin
        check_value("wb_valid", 64'(wb_valid), 64'd1);
        check_value("wb_result", wb_result, q_prod[0]);
        check_value("wb_dest", 64'(wb_dest), 64'(q_dest[0]));
        check_value("wb_npc", wb_npc, q_npc[0]);
        check_value("stall_alu", 64'(stall_alu), 64'd1);
        seen++;
      end else begin
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        check_value("stall_alu", 64'(stall_alu), 64'd0);
      end
      check_value("stall_mult", 64'(stall_mult), 64'(in_mem && front_ready));
      held = in_mem && front_ready;
      cycle++;
      if (cycle >= wait_limit) begin
        $display("%s: multiplier results did not drain within %0d cycles", name, wait_limit);
        timed_out = 1'b1;
      end
    end
    @(posedge clock);
    mult_valid <= 1'b0;
    mem_valid  <= 1'b0;
    check_count++;
    assert (seen == n) else begin
      error_count++;
      $display("%s: only %0d of %0d products reached writeback", name, seen, n);
    end
    report_test(name, chk0, err0);
  endtask

  initial begin
    seed          = 64;
    check_count   = 0;
    error_count   = 0;
    timed_out     = 1'b0;
    alu_valid     = 1'b0;
    alu_func      = alu_addq;
    opa           = '0;
    opb           = '0;
    npc           = '0;
    dest_reg      = '0;
    ir            = '0;
    br_valid      = 1'b0;
    br_func       = '0;
    br_pred_taken = 1'b0;
    pht_idx       = '0;
    mult_valid    = 1'b0;
    mplier        = '0;
    mcand         = '0;
    mult_npc      = '0;
    mult_dest     = '0;
    mem_valid     = 1'b0;
    mem_tag       = '0;
    mem_value     = '0;
    wait_for_reset();
    if (!timed_out) begin
      check_reset_state();
      test_alu_ops();
      test_branches();
      test_halt();
      run_mult_sequence("multiplier", 6, 0, 0);
      // Memory return lands on the first finished product
      run_mult_sequence("mem_priority", 6, mult_stages, 3);
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/ex_pkg.sv
design/alu.sv
design/brcond.sv
design/mult_stage.sv
design/mult.sv
design/ex_arbiter.sv
design/ex_stage.sv
tests/tb_clock.sv
tests/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ex_stage -f compile.f

./obj_dir/Vtb_ex_stage | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  exit 1
fi
